// ==== logic/pdResetPkg.sv ====
package pdResetPkg;

    localparam int numPorts = 4;

    // cycles allowed between the send request and the PHY's sent indication
    localparam int tHardResetCompleteCycles = 300;
    localparam int timerWidth = 9;

    // register map
    localparam logic [3:0] addrTransmitBase = 4'd0;
    localparam logic [3:0] addrAlert = 4'd8;
    localparam logic [3:0] addrBusy = 4'd9;

    // any other code means no request
    typedef enum logic [2:0]
    {
        hardResetCode = 3'd5,
        cableResetCode = 3'd6
    } transmit_t;

    typedef enum logic [5:0]
    {
        waitForResetRequest = 6'b000001,
        constructMessage = 6'b000010,
        waitForHardResetSent = 6'b000100,
        waitForCableResetSent = 6'b001000,
        success = 6'b010000,
        failure = 6'b100000
    } seqState_t;

    // toward the PHY
    typedef struct packed
    {
        logic sendHardReset;
        logic sendCableReset;
        logic stopSending;
    } phyReq_t;

    // from the PHY
    typedef struct packed
    {
        logic hardResetSent;
        logic cableResetSent;
    } phyAck_t;

    typedef struct packed
    {
        logic txSuccessful;
        logic txFailed;
    } portEvent_t;

endpackage

// ==== logic/tcpcRegs.sv ====
`timescale 1ns/1ps

module tcpcRegs
(
    input  logic CLK,
    input  logic RESET,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [3:0] wbAdr,
    input  logic [7:0] wbDatW,
    output logic [7:0] wbDatR,
    output logic wbAck,
    output pdResetPkg::transmit_t transmit [pdResetPkg::numPorts],
    input  logic accepted [pdResetPkg::numPorts],
    input  logic busy [pdResetPkg::numPorts],
    input  logic [7:0] alertBits,
    output logic [7:0] clearMask
);
    import pdResetPkg::*;

    logic wbReq;
    logic wrStrobe;
    logic [7:0] readData;
    logic [7:0] busyWord;

    assign wbReq = wbCyc && wbStb;

    // writes land on the edge where ack is high
    assign wrStrobe = wbAck && wbWe;

    // single-cycle ack, one cycle after the request is seen
    always_ff @(posedge CLK)
    begin
        if (RESET)
            wbAck <= 1'b0;
        else
            wbAck <= wbReq && !wbAck;
    end

    always_comb
    begin
        busyWord = 8'h00;
        for (int p = 0; p < numPorts; p++)
        begin
            busyWord[p] = busy[p];
        end
    end

    // unmapped addresses read as zero
    always_comb
    begin
        readData = 8'h00;
        if (wbAdr == addrAlert)
        begin
            readData = alertBits;
        end
        else if (wbAdr == addrBusy)
        begin
            readData = busyWord;
        end
        else
        begin
            for (int p = 0; p < numPorts; p++)
            begin
                if (wbAdr == 4'(addrTransmitBase + p))
                    readData = {5'b00000, transmit[p]};
            end
        end
    end

    // read data is captured together with the ack
    always_ff @(posedge CLK)
    begin
        if (wbReq && !wbAck)
            wbDatR <= readData;
    end

    // a new write wins over the accept clear, the sequencer already took the old code
    always_ff @(posedge CLK)
    begin
        for (int p = 0; p < numPorts; p++)
        begin
            if (RESET)
                transmit[p] <= transmit_t'(3'd0);
            else if (wrStrobe && wbAdr == 4'(addrTransmitBase + p))
                transmit[p] <= transmit_t'(wbDatW[2:0]);
            else if (accepted[p])
                transmit[p] <= transmit_t'(3'd0);
        end
    end

    // write-one-to-clear pulse for the alert bits
    assign clearMask = (wrStrobe && wbAdr == addrAlert) ? wbDatW : 8'h00;

    ackSingleCycle: assert property (@(posedge CLK) disable iff (RESET)
        wbAck |=> !wbAck)
        else $error("wbAck held high for two cycles");

endmodule

// ==== logic/hardReset.sv ====
`timescale 1ns/1ps

module hardReset
(
    input  logic CLK,
    input  logic RESET,
    input  pdResetPkg::transmit_t transmit,
    output logic accepted,
    output logic busy,
    output pdResetPkg::phyReq_t phyReq,
    input  pdResetPkg::phyAck_t phyAck,
    output pdResetPkg::portEvent_t txEvent
);
    import pdResetPkg::*;

    seqState_t state;
    seqState_t nextState;
    logic hardResetRequest;
    logic cableResetRequest;
    logic cableKind;
    logic [timerWidth-1:0] timer;
    logic timerExpired;

    assign hardResetRequest = (transmit == hardResetCode);
    assign cableResetRequest = (transmit == cableResetCode);

    // the register clears on accept, so the kind is kept here
    assign accepted = (state == waitForResetRequest) && (hardResetRequest || cableResetRequest);
    assign busy = (state != waitForResetRequest);

    // timer is loaded with one in constructMessage, so expiry lands exactly
    // tHardResetCompleteCycles after it
    assign timerExpired = (timer == timerWidth'(tHardResetCompleteCycles - 1));

    always_comb
    begin
        nextState = state;
        case (state)
            waitForResetRequest:
                if (hardResetRequest || cableResetRequest)
                    nextState = constructMessage;
            constructMessage:
                if (cableKind)
                    nextState = waitForCableResetSent;
                else
                    nextState = waitForHardResetSent;
            waitForHardResetSent:
                if (phyAck.hardResetSent)
                    nextState = success;
                else if (timerExpired)
                    nextState = failure;
            // a hard reset indication does not complete a cable reset
            waitForCableResetSent:
                if (phyAck.cableResetSent)
                    nextState = success;
                else if (timerExpired)
                    nextState = failure;
            success:
                nextState = waitForResetRequest;
            failure:
                nextState = waitForResetRequest;
            default:
                nextState = waitForResetRequest;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= waitForResetRequest;
            cableKind <= 1'b0;
            timer <= '0;
        end
        else
        begin
            state <= nextState;
            if (accepted)
                cableKind <= cableResetRequest;
            if (state == constructMessage)
                timer <= timerWidth'(1);
            else if (state == waitForHardResetSent || state == waitForCableResetSent)
                timer <= timer + 1'b1;
            else
                timer <= '0;
        end
    end

    assign phyReq.sendHardReset = (state == constructMessage) && !cableKind;
    assign phyReq.sendCableReset = (state == constructMessage) && cableKind;
    assign phyReq.stopSending = (state == failure);

    assign txEvent.txSuccessful = (state == success);
    assign txEvent.txFailed = (state == failure);

    stateOneHot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot(state))
        else $error("sequencer state is not one-hot");

    sendExclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(phyReq.sendHardReset && phyReq.sendCableReset))
        else $error("hard and cable reset requested together");

    outcomeExclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(txEvent.txSuccessful && txEvent.txFailed))
        else $error("success and failure reported together");

endmodule

// ==== logic/alertCollector.sv ====
`timescale 1ns/1ps

module alertCollector
(
    input  logic CLK,
    input  logic RESET,
    input  pdResetPkg::portEvent_t txEvent [pdResetPkg::numPorts],
    input  logic [7:0] clearMask,
    output logic [7:0] alertBits,
    output logic irq
);
    import pdResetPkg::*;

    logic [7:0] setBits;

    // even bit is success, odd bit is failure of the same port
    always_comb
    begin
        setBits = 8'h00;
        for (int p = 0; p < numPorts; p++)
        begin
            setBits[2*p] = txEvent[p].txSuccessful;
            setBits[2*p+1] = txEvent[p].txFailed;
        end
    end

    // set wins over a clear of the same bit
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            alertBits <= 8'h00;
            irq <= 1'b0;
        end
        else
        begin
            alertBits <= (alertBits & ~clearMask) | setBits;
            irq <= |alertBits;
        end
    end

endmodule

// ==== logic/pdResetTop.sv ====
`timescale 1ns/1ps

module pdResetTop
(
    input  logic CLK,
    input  logic RESET,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [3:0] wbAdr,
    input  logic [7:0] wbDatW,
    output logic [7:0] wbDatR,
    output logic wbAck,
    output pdResetPkg::phyReq_t phyReq [pdResetPkg::numPorts],
    input  pdResetPkg::phyAck_t phyAck [pdResetPkg::numPorts],
    output logic irq
);
    import pdResetPkg::*;

    transmit_t transmit [numPorts];
    logic accepted [numPorts];
    logic busy [numPorts];
    portEvent_t txEvent [numPorts];
    logic [7:0] alertBits;
    logic [7:0] clearMask;

    tcpcRegs tcpcRegs_inst
    (
        .CLK(CLK),
        .RESET(RESET),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .transmit(transmit),
        .accepted(accepted),
        .busy(busy),
        .alertBits(alertBits),
        .clearMask(clearMask)
    );

    // one sequencer per port
    for (genvar p = 0; p < numPorts; p++)
    begin : genPort
        hardReset hardReset_inst
        (
            .CLK(CLK),
            .RESET(RESET),
            .transmit(transmit[p]),
            .accepted(accepted[p]),
            .busy(busy[p]),
            .phyReq(phyReq[p]),
            .phyAck(phyAck[p]),
            .txEvent(txEvent[p])
        );
    end

    alertCollector alertCollector_inst
    (
        .CLK(CLK),
        .RESET(RESET),
        .txEvent(txEvent),
        .clearMask(clearMask),
        .alertBits(alertBits),
        .irq(irq)
    );

endmodule

// ==== tb/pdResetChecker.sv ====
`timescale 1ns/1ps

module pdResetChecker
(
    input  logic CLK,
    input  logic RESET,
    input  logic wbWe,
    input  logic [3:0] wbAdr,
    input  logic [7:0] wbDatW,
    input  logic [7:0] wbDatR,
    input  logic wbAck,
    input  pdResetPkg::phyReq_t phyReq [pdResetPkg::numPorts],
    input  pdResetPkg::phyAck_t phyAck [pdResetPkg::numPorts],
    input  logic irq,
    output int mismatchCount,
    output int faultCount
);
    import pdResetPkg::*;

    typedef enum logic [1:0]
    {
        noRequest = 2'd0,
        txSuccess = 2'd1,
        txFailure = 2'd2
    } outcome_t;

    localparam logic [1:0] kindNone = 2'd0;
    localparam logic [1:0] kindHard = 2'd1;
    localparam logic [1:0] kindCable = 2'd2;

    typedef struct packed
    {
        outcome_t outcome;
        logic [1:0] sendKind;
    } expect_t;

    logic [2:0] pendingCode [numPorts];
    logic [2:0] activeCode [numPorts];
    logic active [numPorts];
    logic tail [numPorts];
    outcome_t tailOutcome [numPorts];
    int count [numPorts];
    logic [2:0] txReg [numPorts];
    logic [2:0] txPrev [numPorts];
    logic [7:0] busyCur;
    logic [7:0] busyPrev;
    logic [7:0] alertReg;
    logic [7:0] alertPrev;
    logic [7:0] setBits;
    logic [7:0] clearBits;
    logic [7:0] expData;
    logic [1:0] seenKind;
    logic matchAck;
    logic checkRead;
    expect_t ex;

    // delay is counted in cycles after the send pulse; the PHY must answer
    // with the matching kind before the timer runs out
    function automatic expect_t expectedOutcome(input logic [2:0] code, input int delay,
                                                input int limit);
        expect_t r;
        r.outcome = noRequest;
        r.sendKind = kindNone;
        if (code == 3'(hardResetCode))
            r.sendKind = kindHard;
        else if (code == 3'(cableResetCode))
            r.sendKind = kindCable;
        if (r.sendKind != kindNone)
        begin
            if (delay >= 1 && delay < limit)
                r.outcome = txSuccess;
            else
                r.outcome = txFailure;
        end
        return r;
    endfunction

    function automatic logic isRequest(input logic [2:0] code);
        return code == 3'(hardResetCode) || code == 3'(cableResetCode);
    endfunction

    task automatic reportMismatch(input string what, input logic [7:0] expected,
                                  input logic [7:0] actual);
        mismatchCount++;
        $display("mismatch in %s: %s expected %h, actual %h",
                 pdResetTb.testName, what, expected, actual);
    endtask

    task automatic reportFault(input string msg);
        faultCount++;
        $display("error in %s: %s", pdResetTb.testName, msg);
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            mismatchCount = 0;
            faultCount = 0;
            busyPrev = 8'h00;
            alertReg = 8'h00;
            alertPrev = 8'h00;
            for (int p = 0; p < numPorts; p++)
            begin
                pendingCode[p] = 3'd0;
                activeCode[p] = 3'd0;
                active[p] = 1'b0;
                tail[p] = 1'b0;
                tailOutcome[p] = noRequest;
                count[p] = 0;
                txReg[p] = 3'd0;
                txPrev[p] = 3'd0;
            end
        end
        else
        begin
            setBits = 8'h00;
            clearBits = 8'h00;
            busyCur = 8'h00;
            for (int p = 0; p < numPorts; p++)
            begin
                // outcome state: one cycle, still busy
                if (tail[p])
                begin
                    busyCur[p] = 1'b1;
                    tail[p] = 1'b0;
                    if (tailOutcome[p] == txSuccess)
                        setBits[2*p] = 1'b1;
                    else
                        setBits[2*p+1] = 1'b1;
                    if (phyReq[p].stopSending != (tailOutcome[p] == txFailure))
                        reportFault($sformatf("stopSending on port %0d does not fit the outcome", p));
                end
                else if (phyReq[p].stopSending)
                    reportFault($sformatf("stopSending on port %0d without a timeout", p));

                if (phyReq[p].sendHardReset || phyReq[p].sendCableReset)
                begin
                    seenKind = phyReq[p].sendCableReset ? kindCable : kindHard;
                    ex = expectedOutcome(pendingCode[p], 0, tHardResetCompleteCycles);
                    if (active[p])
                        reportFault($sformatf("send pulse on port %0d while it is busy", p));
                    else if (ex.sendKind == kindNone)
                        reportFault($sformatf("send pulse on port %0d with no request", p));
                    else if (ex.sendKind != seenKind)
                        reportMismatch($sformatf("send kind of port %0d", p),
                                       {6'b0, ex.sendKind}, {6'b0, seenKind});
                    busyCur[p] = 1'b1;
                    active[p] = 1'b1;
                    count[p] = 0;
                    activeCode[p] = pendingCode[p];
                    pendingCode[p] = 3'd0;
                end
                else if (active[p])
                begin
                    busyCur[p] = 1'b1;
                    count[p]++;
                    if (activeCode[p] == 3'(cableResetCode))
                        matchAck = phyAck[p].cableResetSent;
                    else
                        matchAck = phyAck[p].hardResetSent;
                    if (matchAck || count[p] == tHardResetCompleteCycles - 1)
                    begin
                        ex = expectedOutcome(activeCode[p],
                                             matchAck ? count[p] : tHardResetCompleteCycles,
                                             tHardResetCompleteCycles);
                        active[p] = 1'b0;
                        tail[p] = (ex.outcome != noRequest);
                        tailOutcome[p] = ex.outcome;
                    end
                end
            end

            // irq follows the alert bits by one cycle
            if (irq != |alertPrev)
                reportMismatch("irq", {7'b0, |alertPrev}, {7'b0, irq});

            // read data was captured in the cycle before the ack
            if (wbAck && !wbWe)
            begin
                checkRead = 1'b1;
                expData = 8'h00;
                if (wbAdr == addrAlert)
                    expData = alertPrev;
                else if (wbAdr == addrBusy)
                    expData = busyPrev;
                else if (wbAdr < 4'(numPorts))
                begin
                    expData = {5'b00000, txPrev[wbAdr[1:0]]};
                    checkRead = !isRequest(txPrev[wbAdr[1:0]]);
                end
                if (checkRead && wbDatR != expData)
                    reportMismatch($sformatf("read of address %0d", wbAdr), expData, wbDatR);
            end

            busyPrev = busyCur;
            alertPrev = alertReg;
            for (int p = 0; p < numPorts; p++)
            begin
                txPrev[p] = txReg[p];
            end

            if (wbAck && wbWe)
            begin
                if (wbAdr < 4'(numPorts))
                begin
                    pendingCode[wbAdr[1:0]] = wbDatW[2:0];
                    txReg[wbAdr[1:0]] = wbDatW[2:0];
                end
                else if (wbAdr == addrAlert)
                    clearBits = wbDatW;
            end
            alertReg = (alertReg & ~clearBits) | setBits;
        end
    end

endmodule

// ==== tb/pdResetTb.sv ====
`timescale 1ns/1ps

module pdResetTb;
    import pdResetPkg::*;

    localparam int numTests = 6;
    localparam int cycleLimit = numTests * (tHardResetCompleteCycles + 100);
    localparam int maxDelay = 40;

    logic CLK;
    logic RESET;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [3:0] wbAdr;
    logic [7:0] wbDatW;
    logic [7:0] wbDatR;
    logic wbAck;
    phyReq_t phyReq [numPorts];
    phyAck_t phyAck [numPorts];
    logic irq;

    int mismatchCount;
    int faultCount;
    int cycleCount;
    logic noAnswer [numPorts];
    logic wrongKind [numPorts];
    string testName;
    logic [7:0] readValue;
    logic [2:0] randomCode;
    logic [2:0] plainCodes [6] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};

    pdResetTop pdResetTop_inst
    (
        .CLK(CLK),
        .RESET(RESET),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .phyReq(phyReq),
        .phyAck(phyAck),
        .irq(irq)
    );

    pdResetChecker checker_inst
    (
        .CLK(CLK),
        .RESET(RESET),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .phyReq(phyReq),
        .phyAck(phyAck),
        .irq(irq),
        .mismatchCount(mismatchCount),
        .faultCount(faultCount)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout: run stopped after %0d cycles in %s", cycleCount, testName);
            $display("Test failed");
            $finish;
        end
    end

    task automatic wbWrite(input logic [3:0] addr, input logic [7:0] data);
        @(posedge CLK);
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = addr;
        wbDatW = data;
        @(posedge CLK);
        while (!wbAck)
            @(posedge CLK);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbRead(input logic [3:0] addr, output logic [7:0] data);
        @(posedge CLK);
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = addr;
        @(posedge CLK);
        while (!wbAck)
            @(posedge CLK);
        data = wbDatR;
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    // poll the busy register until every port is idle
    task automatic waitIdle();
        logic [7:0] value;
        value = 8'hff;
        while (value != 8'h00)
            wbRead(addrBusy, value);
    endtask

    // answers each send pulse after a random delay, or never
    task automatic phyResponder(input int port);
        int delay;
        logic cable;
        forever
        begin
            @(posedge CLK);
            if (phyReq[port].sendHardReset || phyReq[port].sendCableReset)
            begin
                cable = phyReq[port].sendCableReset;
                delay = int'($urandom_range(maxDelay, 1));
                if (!noAnswer[port])
                begin
                    repeat (delay - 1) @(posedge CLK);
                    #1;
                    if (cable != wrongKind[port])
                        phyAck[port].cableResetSent = 1'b1;
                    else
                        phyAck[port].hardResetSent = 1'b1;
                    @(posedge CLK);
                    #1;
                    phyAck[port] = '0;
                end
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'he800_9954));
        cycleCount = 0;
        testName = "reset";
        RESET = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = 4'd0;
        wbDatW = 8'h00;
        for (int p = 0; p < numPorts; p++)
        begin
            phyAck[p] = '0;
            noAnswer[p] = 1'b0;
            wrongKind[p] = 1'b0;
        end
        for (int p = 0; p < numPorts; p++)
        begin
            fork
                automatic int port = p;
                phyResponder(port);
            join_none
        end
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;

        testName = "hard reset success";
        wbWrite(4'd1, 8'h05);
        waitIdle();
        repeat (3) @(posedge CLK);
        wbRead(addrAlert, readValue);

        testName = "cable reset";
        wbWrite(4'd2, 8'h06);
        waitIdle();
        wbRead(addrAlert, readValue);
        // hard reset indication answers a cable reset request
        wrongKind[2] = 1'b1;
        wbWrite(4'd2, 8'h06);
        waitIdle();
        wbRead(addrAlert, readValue);
        wrongKind[2] = 1'b0;

        testName = "no answer timeout";
        noAnswer[3] = 1'b1;
        wbWrite(4'd3, 8'h05);
        waitIdle();
        wbRead(addrAlert, readValue);
        noAnswer[3] = 1'b0;

        testName = "codes without request";
        for (int i = 0; i < 6; i++)
        begin
            wbWrite(4'd0, {5'b00000, plainCodes[i]});
            wbRead(4'd0, readValue);
            repeat (4) @(posedge CLK);
            wbRead(addrBusy, readValue);
        end
        wbRead(addrAlert, readValue);
        wbRead(4'd12, readValue);

        testName = "alert clear and busy";
        wbWrite(addrAlert, 8'h04);
        wbRead(addrAlert, readValue);
        wbWrite(addrAlert, 8'hff);
        repeat (3) @(posedge CLK);
        wbRead(addrAlert, readValue);
        noAnswer[0] = 1'b1;
        wbWrite(4'd0, 8'h05);
        repeat (20) @(posedge CLK);
        wbRead(addrBusy, readValue);
        waitIdle();
        wbRead(addrBusy, readValue);
        wbRead(addrAlert, readValue);
        wbWrite(addrAlert, 8'hff);
        noAnswer[0] = 1'b0;

        testName = "all ports random";
        for (int p = 0; p < numPorts; p++)
        begin
            if ($urandom_range(1, 0) == 1)
                randomCode = ($urandom_range(1, 0) == 1) ? 3'd5 : 3'd6;
            else
                randomCode = 3'($urandom_range(7, 0));
            wbWrite(4'(p), {5'b00000, randomCode});
        end
        waitIdle();
        repeat (3) @(posedge CLK);
        wbRead(addrAlert, readValue);

        repeat (4) @(posedge CLK);
        $display("errors: %0d mismatches, %0d other faults", mismatchCount, faultCount);
        if (mismatchCount == 0 && faultCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== src.f ====
logic/pdResetPkg.sv
logic/tcpcRegs.sv
logic/hardReset.sv
logic/alertCollector.sv
logic/pdResetTop.sv
tb/pdResetChecker.sv
tb/pdResetTb.sv

// ==== Makefile ====
TOP = pdResetTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --top-module $(TOP) -f src.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
